/* sim/histPatterns.txt */
// columns: kind[31:28] flags[27:24] pixel[23:20] bin[19:16] count[15:0]
// kind 1 sample burst (flag 1 frame end, flag 2 no gaps), kind 2 expected peak
// frame 1, distinct hits per pixel
10030003
10050001
101a0004
10120002
102f0002
10200001
10370005
11380002
20030003
201a0004
202f0002
20370005
// frame 2, back-to-back hits on one address and alternating addresses
12160009
12170001
12160003
12010001
12020001
12010001
12020001
12010001
12290007
13340005
20010003
2016000c
20290007
20340005
// frame 3, 300 hits saturate
122c012c
1023000a
10000001
101f0002
11310001
20000001
201f0002
202c00ff
20310001
// frame 4, ties keep the lowest bin, pixel 1 empty
10090002
10040002
10200003
102d0003
10320001
113b0001
20040002
20100000
20200003
20320001
// frame 5, nothing left from earlier frames
10150001
113e0002
20000000
20150001
20200000
203e0002

/* files.f */
source/histPkg.sv
source/histMemory.sv
source/histUpdater.sv
source/peakSweep.sv
source/histTop.sv
sim/histTb.sv

/* run.sh */
#!/bin/sh
# build and run the histogram testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module histTb -f files.f -o histSim

./obj_dir/histSim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* sim/histTb.sv */
`timescale 1ns/100ps

module histTb;

    localparam int recordMax = 64;
    localparam int timeoutCycles = 2000;

    logic                           clk;
    logic                           rst;
    logic                           sampleValid;
    logic [histPkg::pixelWidth-1:0] samplePixel;
    logic [histPkg::binWidth-1:0]   sampleBin;
    logic                           frameLast;
    logic                           creditReturn;
    logic                           peakValid;
    logic [histPkg::pixelWidth-1:0] peakPixel;
    logic [histPkg::binWidth-1:0]   peakBin;
    logic [histPkg::countWidth-1:0] peakCount;

    // kind, flags, pixel, bin, count per record
    logic [31:0] patterns [recordMax];

    int seed;
    int samplesSent;
    int creditsReturned;
    int errorCount;
    int testErrors;
    int testNumber;
    int testsPassed;
    int testsFailed;
    int idx;
    bit timedOut;

    histTop i_dut (
        .clk         (clk),
        .rst         (rst),
        .sampleValid (sampleValid),
        .samplePixel (samplePixel),
        .sampleBin   (sampleBin),
        .frameLast   (frameLast),
        .creditReturn(creditReturn),
        .peakValid   (peakValid),
        .peakPixel   (peakPixel),
        .peakBin     (peakBin),
        .peakCount   (peakCount)
    );

    initial begin
        clk = 1'b0;
    end

    always begin
        #4 clk = ~clk;
    end

    function automatic int creditsAvailable();
        return histPkg::creditDepth - samplesSent + creditsReturned;
    endfunction

    function automatic string testName(input int n);
        case (n)
            1: return "basic peaks";
            2: return "forwarding";
            3: return "saturation";
            4: return "ties and empty pixels";
            5: return "clearing";
            default: return "extra frame";
        endcase
    endfunction

    task automatic countError();
        errorCount++;
        testErrors++;
    endtask

    // creditReturn is stable mid-cycle, the pop happens at the next edge
    always @(negedge clk) begin
        if (!rst && creditReturn) begin
            creditsReturned = creditsReturned + 1;
            if (creditsAvailable() > histPkg::creditDepth) begin
                $display("credit overflow at %0t: sender would hold %0d credits",
                         $time, creditsAvailable());
                countError();
            end
        end
    end

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            sampleValid <= 1'b0;
            frameLast   <= 1'b0;
        end
    endtask

    // stalls while out of credits
    task automatic sendSample(input logic [histPkg::pixelWidth-1:0] pixel,
                              input logic [histPkg::binWidth-1:0] bin,
                              input logic last);
        int waited;
        waited = 0;
        @(posedge clk);
        while (creditsAvailable() == 0 && waited < timeoutCycles) begin
            sampleValid <= 1'b0;
            frameLast   <= 1'b0;
            @(posedge clk);
            waited++;
        end
        if (creditsAvailable() == 0) begin
            $display("at %0t the sender had no credit for %0d cycles, pixel %0d bin %0d not sent",
                     $time, timeoutCycles, pixel, bin);
            countError();
            timedOut = 1'b1;
            sampleValid <= 1'b0;
            frameLast   <= 1'b0;
        end else begin
            sampleValid <= 1'b1;
            samplePixel <= pixel;
            sampleBin   <= bin;
            frameLast   <= last;
            samplesSent++;
        end
    endtask

    // flag bit 0 marks frame end on the final sample, bit 1 drops the gaps
    task automatic runSamples(input logic [31:0] rec);
        int gap;
        int count;
        count = int'(rec[15:0]);
        for (int n = 0; n < count && !timedOut; n++) begin
            if (!rec[25]) begin
                gap = $unsigned($random(seed)) % 4;
                idleCycles(gap);
            end
            sendSample(rec[20 +: histPkg::pixelWidth], rec[16 +: histPkg::binWidth],
                       rec[24] && (n == count - 1));
        end
    endtask

    task automatic compareValue(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            countError();
        end
    endtask

    // credits must be back to full once the sweep is over
    task automatic finishTest();
        int waited;
        waited = 0;
        while (creditsAvailable() != histPkg::creditDepth && waited < timeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (creditsAvailable() != histPkg::creditDepth) begin
            $display("at %0t the sender holds %0d credits after the sweep instead of %0d",
                     $time, creditsAvailable(), histPkg::creditDepth);
            countError();
        end
        if (testErrors == 0) begin
            $display("test %0d %s: ok", testNumber, testName(testNumber));
            testsPassed++;
        end else begin
            $display("test %0d %s: failed with %0d errors", testNumber, testName(testNumber),
                     testErrors);
            testsFailed++;
        end
        testErrors = 0;
        testNumber++;
    endtask

    task automatic checkPeak(input logic [31:0] rec);
        int waited;
        logic [histPkg::pixelWidth-1:0] expPixel;
        expPixel = rec[20 +: histPkg::pixelWidth];
        waited = 0;
        // release sampleValid after the frame end
        idleCycles(1);
        @(negedge clk);
        while (!peakValid && waited < timeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (!peakValid) begin
            $display("at %0t no peak report came for pixel %0d within %0d cycles",
                     $time, expPixel, timeoutCycles);
            countError();
            timedOut = 1'b1;
        end else begin
            compareValue("peakPixel", 16'(expPixel), 16'(peakPixel));
            compareValue("peakBin", 16'(rec[16 +: histPkg::binWidth]), 16'(peakBin));
            compareValue("peakCount", 16'(rec[0 +: histPkg::countWidth]), 16'(peakCount));
        end
        // last pixel closes the frame
        if (expPixel == histPkg::pixelWidth'(histPkg::pixelNum - 1)) begin
            finishTest();
        end
    endtask

    initial begin
        seed            = 4;
        samplesSent     = 0;
        creditsReturned = 0;
        errorCount      = 0;
        testErrors      = 0;
        testNumber      = 1;
        testsPassed     = 0;
        testsFailed     = 0;
        timedOut        = 1'b0;
        rst             = 1'b1;
        sampleValid     = 1'b0;
        samplePixel     = '0;
        sampleBin       = '0;
        frameLast       = 1'b0;
        for (int i = 0; i < recordMax; i++) begin
            patterns[i] = '0;
        end
        $readmemh("sim/histPatterns.txt", patterns);

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // a zero record ends the list
        idx = 0;
        while (idx < recordMax && patterns[idx][31:28] != 4'h0 && !timedOut) begin
            case (patterns[idx][31:28])
                4'h1: runSamples(patterns[idx]);
                4'h2: checkPeak(patterns[idx]);
                default: begin
                    $display("record %0d has unknown kind %0h", idx, patterns[idx][31:28]);
                    countError();
                end
            endcase
            idx++;
        end

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsPassed > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* source/histTop.sv */
`timescale 1ns/100ps

module histTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            sampleValid,
    input  logic [histPkg::pixelWidth-1:0]  samplePixel,
    input  logic [histPkg::binWidth-1:0]    sampleBin,
    input  logic                            frameLast,
    output logic                            creditReturn,
    output logic                            peakValid,
    output logic [histPkg::pixelWidth-1:0]  peakPixel,
    output logic [histPkg::binWidth-1:0]    peakBin,
    output logic [histPkg::countWidth-1:0]  peakCount
);

    // updater side of the memory
    logic [histPkg::addrWidth-1:0]  updRdAddr;
    logic                           updRdEn;
    logic [histPkg::addrWidth-1:0]  updWrAddr;
    logic                           updWrEn;
    logic [histPkg::countWidth-1:0] updWrData;

    // sweep side of the memory
    logic [histPkg::addrWidth-1:0]  swpRdAddr;
    logic                           swpRdEn;
    logic [histPkg::addrWidth-1:0]  swpWrAddr;
    logic                           swpWrEn;

    // shared read data, owner picked by sweepActive
    logic [histPkg::countWidth-1:0] rdData;

    // frame handoff
    logic                           sweepStart;
    logic                           sweepDone;
    logic                           sweepActive;

    histUpdater i_updater (
        .clk         (clk),
        .rst         (rst),
        .sampleValid (sampleValid),
        .samplePixel (samplePixel),
        .sampleBin   (sampleBin),
        .frameLast   (frameLast),
        .creditReturn(creditReturn),
        .rdAddr      (updRdAddr),
        .rdEn        (updRdEn),
        .rdData      (rdData),
        .wrAddr      (updWrAddr),
        .wrEn        (updWrEn),
        .wrData      (updWrData),
        .sweepStart  (sweepStart),
        .sweepActive (sweepActive),
        .sweepDone   (sweepDone)
    );

    peakSweep i_sweep (
        .clk        (clk),
        .rst        (rst),
        .sweepStart (sweepStart),
        .sweepActive(sweepActive),
        .sweepDone  (sweepDone),
        .rdAddr     (swpRdAddr),
        .rdEn       (swpRdEn),
        .wrAddr     (swpWrAddr),
        .wrEn       (swpWrEn),
        .rdData     (rdData),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

    histMemory i_memory (
        .clk        (clk),
        .sweepActive(sweepActive),
        .updRdAddr  (updRdAddr),
        .updRdEn    (updRdEn),
        .updWrAddr  (updWrAddr),
        .updWrEn    (updWrEn),
        .updWrData  (updWrData),
        .swpRdAddr  (swpRdAddr),
        .swpRdEn    (swpRdEn),
        .swpWrAddr  (swpWrAddr),
        .swpWrEn    (swpWrEn),
        .rdData     (rdData)
    );

endmodule

/* source/peakSweep.sv */
`timescale 1ns/100ps

module peakSweep (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            sweepStart,
    output logic                            sweepActive,
    output logic                            sweepDone,
    output logic [histPkg::addrWidth-1:0]   rdAddr,
    output logic                            rdEn,
    output logic [histPkg::addrWidth-1:0]   wrAddr,
    output logic                            wrEn,
    input  logic [histPkg::countWidth-1:0]  rdData,
    output logic                            peakValid,
    output logic [histPkg::pixelWidth-1:0]  peakPixel,
    output logic [histPkg::binWidth-1:0]    peakBin,
    output logic [histPkg::countWidth-1:0]  peakCount
);

    histPkg::sweepState state;

    logic [histPkg::pixelWidth-1:0] pixelIdx;
    logic [histPkg::binWidth-1:0]   binIdx;

    // read one cycle ago, data valid now
    logic                           rdValidQ;
    logic [histPkg::addrWidth-1:0]  rdAddrQ;
    logic [histPkg::binWidth-1:0]   dataBin;

    // running maximum of the current pixel
    logic [histPkg::countWidth-1:0] maxCount;
    logic [histPkg::binWidth-1:0]   maxBin;
    logic [histPkg::countWidth-1:0] nextMax;
    logic [histPkg::binWidth-1:0]   nextBin;

    assign rdEn    = (state == histPkg::sweepScan);
    assign rdAddr  = {pixelIdx, binIdx};
    assign dataBin = rdAddrQ[histPkg::binWidth-1:0];

    // clear each word one cycle after its read
    assign wrEn   = rdValidQ;
    assign wrAddr = rdAddrQ;

    // bin 0 restarts the max, only strictly greater replaces it
    always_comb begin
        nextMax = maxCount;
        nextBin = maxBin;
        if (dataBin == '0) begin
            nextMax = rdData;
            nextBin = '0;
        end else if (rdData > maxCount) begin
            nextMax = rdData;
            nextBin = dataBin;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= histPkg::sweepIdle;
            pixelIdx    <= '0;
            binIdx      <= '0;
            rdValidQ    <= 1'b0;
            sweepActive <= 1'b0;
            sweepDone   <= 1'b0;
            peakValid   <= 1'b0;
        end else begin
            rdValidQ  <= rdEn;
            peakValid <= 1'b0;
            sweepDone <= 1'b0;
            // held through the last report
            if (sweepDone) begin
                sweepActive <= 1'b0;
            end
            case (state)
                histPkg::sweepIdle: begin
                    if (sweepStart) begin
                        state       <= histPkg::sweepScan;
                        pixelIdx    <= '0;
                        binIdx      <= '0;
                        sweepActive <= 1'b1;
                    end
                end
                histPkg::sweepScan: begin
                    binIdx <= binIdx + 1'b1;
                    if (binIdx == histPkg::binWidth'(histPkg::binNum - 1)) begin
                        state <= histPkg::sweepReport;
                    end
                end
                histPkg::sweepReport: begin
                    // last bin's data arrives this cycle
                    peakValid <= 1'b1;
                    pixelIdx  <= pixelIdx + 1'b1;
                    if (pixelIdx == histPkg::pixelWidth'(histPkg::pixelNum - 1)) begin
                        state     <= histPkg::sweepIdle;
                        sweepDone <= 1'b1;
                    end else begin
                        state <= histPkg::sweepScan;
                    end
                end
                default: state <= histPkg::sweepIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rdAddrQ <= rdAddr;
        if (rdValidQ) begin
            maxCount <= nextMax;
            maxBin   <= nextBin;
        end
        if (state == histPkg::sweepReport) begin
            peakPixel <= pixelIdx;
            peakBin   <= nextBin;
            peakCount <= nextMax;
        end
    end

    // reports only come out of an active sweep
    peakInsideSweep: assert property (
        @(posedge clk) disable iff (rst) peakValid |-> sweepActive
    );

endmodule

/* source/histUpdater.sv */
`timescale 1ns/100ps

module histUpdater (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            sampleValid,
    input  logic [histPkg::pixelWidth-1:0]  samplePixel,
    input  logic [histPkg::binWidth-1:0]    sampleBin,
    input  logic                            frameLast,
    output logic                            creditReturn,
    output logic [histPkg::addrWidth-1:0]   rdAddr,
    output logic                            rdEn,
    input  logic [histPkg::countWidth-1:0]  rdData,
    output logic [histPkg::addrWidth-1:0]   wrAddr,
    output logic                            wrEn,
    output logic [histPkg::countWidth-1:0]  wrData,
    output logic                            sweepStart,
    input  logic                            sweepActive,
    input  logic                            sweepDone
);

    histPkg::updState state;

    // credit buffer
    logic [histPkg::addrWidth-1:0]   bufAddr [histPkg::creditDepth];
    logic                            bufLast [histPkg::creditDepth];
    logic [histPkg::bufPtrWidth-1:0] wrPtr;
    logic [histPkg::bufPtrWidth-1:0] rdPtr;
    logic [histPkg::bufPtrWidth:0]   bufCount;
    logic                            canPop;
    logic                            pop;
    logic                            popLast;

    // stage 1 waits for read data, stage 2 writes
    logic                            s1Valid;
    logic [histPkg::addrWidth-1:0]   s1Addr;
    logic                            s1Last;
    logic [histPkg::countWidth-1:0]  s1Count;
    logic [histPkg::countWidth-1:0]  s1Inc;
    logic                            s2Valid;
    logic [histPkg::addrWidth-1:0]   s2Addr;
    logic                            s2Last;
    logic [histPkg::countWidth-1:0]  s2Data;

    // write of the previous cycle, landed on the same edge as the s1 read
    logic                            prevValid;
    logic [histPkg::addrWidth-1:0]   prevAddr;
    logic [histPkg::countWidth-1:0]  prevData;

    // no pops once a frame end is taken, nor during the sweep
    assign canPop  = (state == histPkg::updIdle) || (state == histPkg::updRead);
    assign pop     = (bufCount != '0) && canPop && !sweepActive;
    assign popLast = bufLast[rdPtr];

    // read issued and credit returned in the pop cycle
    assign creditReturn = pop;
    assign rdEn         = pop;
    assign rdAddr       = bufAddr[rdPtr];

    // newest write wins, then the one already in memory but missed by the read
    always_comb begin
        if (s2Valid && (s2Addr == s1Addr)) begin
            s1Count = s2Data;
        end else if (prevValid && (prevAddr == s1Addr)) begin
            s1Count = prevData;
        end else begin
            s1Count = rdData;
        end
    end

    // saturate at full scale
    assign s1Inc = (s1Count == histPkg::countMax) ? s1Count : s1Count + 1'b1;

    assign wrEn   = s2Valid;
    assign wrAddr = s2Addr;
    assign wrData = s2Data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= histPkg::updIdle;
            wrPtr      <= '0;
            rdPtr      <= '0;
            bufCount   <= '0;
            s1Valid    <= 1'b0;
            s2Valid    <= 1'b0;
            prevValid  <= 1'b0;
            sweepStart <= 1'b0;
        end else begin
            if (sampleValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({sampleValid, pop})
                2'b10:   bufCount <= bufCount + 1'b1;
                2'b01:   bufCount <= bufCount - 1'b1;
                default: bufCount <= bufCount;
            endcase

            s1Valid    <= pop;
            s2Valid    <= s1Valid;
            prevValid  <= s2Valid;
            sweepStart <= 1'b0;

            case (state)
                histPkg::updIdle: begin
                    if (pop) begin
                        state <= popLast ? histPkg::updWrite : histPkg::updRead;
                    end
                end
                histPkg::updRead: begin
                    if (pop && popLast) begin
                        state <= histPkg::updWrite;
                    end else if (!pop && !s1Valid) begin
                        // only s2 left, its write lands this edge
                        state <= histPkg::updIdle;
                    end
                end
                histPkg::updWrite: begin
                    // frame-last write completes at this edge
                    if (s2Valid && s2Last) begin
                        state      <= histPkg::updDrain;
                        sweepStart <= 1'b1;
                    end
                end
                histPkg::updDrain: begin
                    if (sweepDone) begin
                        state <= histPkg::updIdle;
                    end
                end
                default: state <= histPkg::updIdle;
            endcase
        end
    end

    // buffer payload and pipeline data
    always_ff @(posedge clk) begin
        if (sampleValid) begin
            bufAddr[wrPtr] <= {samplePixel, sampleBin};
            bufLast[wrPtr] <= frameLast;
        end
        s1Addr   <= rdAddr;
        s1Last   <= popLast;
        s2Addr   <= s1Addr;
        s2Last   <= s1Last;
        s2Data   <= s1Inc;
        prevAddr <= s2Addr;
        prevData <= s2Data;
    end

    // sender holds at most creditDepth credits
    bufNoOverflow: assert property (
        @(posedge clk) disable iff (rst) bufCount <= histPkg::creditDepth
    );

    // a full buffer means the sender is out of credits
    noSampleWhenFull: assert property (
        @(posedge clk) disable iff (rst) (bufCount == histPkg::creditDepth) |-> !sampleValid
    );

endmodule

/* source/histMemory.sv */
`timescale 1ns/100ps

module histMemory (
    input  logic                            clk,
    input  logic                            sweepActive,
    input  logic [histPkg::addrWidth-1:0]   updRdAddr,
    input  logic                            updRdEn,
    input  logic [histPkg::addrWidth-1:0]   updWrAddr,
    input  logic                            updWrEn,
    input  logic [histPkg::countWidth-1:0]  updWrData,
    input  logic [histPkg::addrWidth-1:0]   swpRdAddr,
    input  logic                            swpRdEn,
    input  logic [histPkg::addrWidth-1:0]   swpWrAddr,
    input  logic                            swpWrEn,
    output logic [histPkg::countWidth-1:0]  rdData
);

    logic [histPkg::countWidth-1:0] mem [histPkg::pixelNum*histPkg::binNum];

    logic [histPkg::addrWidth-1:0] rdAddr;
    logic                          rdEn;
    logic [histPkg::addrWidth-1:0] wrAddr;
    logic                          wrEn;

    // port owner follows sweepActive
    assign rdAddr = sweepActive ? swpRdAddr : updRdAddr;
    assign rdEn   = sweepActive ? swpRdEn   : updRdEn;
    assign wrAddr = sweepActive ? swpWrAddr : updWrAddr;
    assign wrEn   = sweepActive ? swpWrEn   : updWrEn;

    // power-up content zero, later frames are cleared by the sweep
    initial begin
        for (int i = 0; i < histPkg::pixelNum*histPkg::binNum; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        // sweep side only ever clears
        if (wrEn) begin
            mem[wrAddr] <= sweepActive ? '0 : updWrData;
        end
        // old data on a same-address read, updater forwards around it
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

    // updater must be parked for the whole sweep
    updParkedDuringSweep: assert property (
        @(posedge clk) sweepActive |-> !(updRdEn || updWrEn)
    );

endmodule

/* source/histPkg.sv */
package histPkg;

    // histogram geometry
    localparam int pixelNum = 4;
    localparam int pixelWidth = 2;
    localparam int binNum = 16;
    localparam int binWidth = 4;

    // memory address is {pixel, bin}
    localparam int addrWidth = pixelWidth + binWidth;

    // one count per pixel and bin, saturating
    localparam int countWidth = 8;
    localparam logic [countWidth-1:0] countMax = '1;

    // input buffer depth, equal to the sender's starting credits
    localparam int creditDepth = 4;
    localparam int bufPtrWidth = 2;

    // updater control
    // idle   nothing in flight
    // read   samples popping and pipelining
    // write  frame-last sample popped, waiting for its write
    // drain  sweep requested, waiting for sweepDone
    typedef enum logic [1:0] {
        updIdle,
        updRead,
        updWrite,
        updDrain
    } updState;

    // sweep control
    typedef enum logic [1:0] {
        sweepIdle,
        sweepScan,
        sweepReport
    } sweepState;

endpackage
